// File: source/usb_rx_pkg.sv
package usb_rx_pkg;

    // ********************
    // line and bit level
    // ********************

    // encoded as {d_plus, d_minus}
    typedef enum logic [1:0] {
        LINE_SE0 = 2'b00,
        LINE_K   = 2'b01,
        LINE_J   = 2'b10,
        LINE_SE1 = 2'b11
    } line_state_t;

    typedef struct packed {
        logic valid;
        logic value;
        logic eop;
    } rx_bit_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       eop;
        // only meaningful with eop
        logic       aligned;
    } rx_byte_t;

    // ********************
    // packet level
    // ********************

    typedef enum logic [2:0] {
        PKT_NONE        = 3'd0,
        PKT_IN          = 3'd1,
        PKT_OUT         = 3'd2,
        PKT_DATA        = 3'd3,
        PKT_ACK         = 3'd4,
        PKT_NAK         = 3'd5,
        PKT_UNSUPPORTED = 3'd6
    } rx_packet_t;

    typedef enum logic [7:0] {
        PID_OUT   = 8'hE1,
        PID_IN    = 8'h69,
        PID_DATA0 = 8'hC3,
        PID_DATA1 = 8'h4B,
        PID_ACK   = 8'hD2,
        PID_NAK   = 8'h5A
    } pid_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SYNC,
        ST_PID,
        ST_TOKEN,
        ST_DATA,
        ST_HANDSHAKE,
        ST_WAIT_EOP
    } rx_state_t;

    // sync pattern KJKJKJKK, decoded LSB first
    localparam logic [7:0] SYNC_BYTE = 8'h80;
    localparam int STUFF_RUN = 6;

endpackage

// File: source/line_sampler.sv
module line_sampler
    import usb_rx_pkg::*;
#(
    parameter int clks_per_bit = 8
) (
    input  logic        tb_clk,
    input  logic        tb_n_rst,
    input  logic        d_plus,
    input  logic        d_minus,
    output line_state_t line,
    output logic        sample
);

    localparam int PHASE_W = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam int HALF = clks_per_bit / 2;

    line_state_t        sync_1;
    line_state_t        sync_2;
    logic [PHASE_W-1:0] phase;

    // two flop synchronizer, bus idles at J
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            sync_1 <= LINE_J;
            sync_2 <= LINE_J;
        end else begin
            sync_1 <= line_state_t'({d_plus, d_minus});
            sync_2 <= sync_1;
        end
    end

    // phase restarts on every line edge so the sample point tracks the sender
    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            line  <= LINE_J;
            phase <= '0;
        end else begin
            line <= sync_2;
            if (sync_2 != line) begin
                phase <= '0;
            end else if (phase == PHASE_W'(clks_per_bit - 1)) begin
                phase <= '0;
            end else begin
                phase <= phase + PHASE_W'(1);
            end
        end
    end

    // mid cell, half a bit after the last edge
    assign sample = (phase == PHASE_W'(HALF - 1));

endmodule

// File: source/nrzi_decoder.sv
module nrzi_decoder
    import usb_rx_pkg::*;
(
    input  logic        tb_clk,
    input  logic        tb_n_rst,
    input  line_state_t line,
    input  logic        sample,
    output rx_bit_t     bit_out
);

    logic        active;
    line_state_t prev;
    logic [2:0]  ones;
    logic        same;

    // nrzi, no transition means a one
    assign same = (line == prev);

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            active  <= 1'b0;
            prev    <= LINE_J;
            ones    <= '0;
            bit_out <= '0;
        end else begin
            bit_out <= '0;
            if (sample) begin
                if (line == LINE_SE0) begin
                    // only the first SE0 sample of a packet counts
                    bit_out.eop <= active;
                    active      <= 1'b0;
                    prev        <= LINE_J;
                    ones        <= '0;
                end else if (line != LINE_SE1) begin
                    prev <= line;
                    if (!active) begin
                        // first K after idle opens the packet with a zero
                        if (!same) begin
                            active        <= 1'b1;
                            bit_out.valid <= 1'b1;
                            bit_out.value <= 1'b0;
                            ones          <= '0;
                        end
                    end else if (ones == 3'(STUFF_RUN)) begin
                        // stuffed zero, dropped
                        ones <= '0;
                    end else begin
                        bit_out.valid <= 1'b1;
                        bit_out.value <= same;
                        ones          <= same ? ones + 3'd1 : 3'd0;
                    end
                end
            end
        end
    end

endmodule

// File: source/byte_assembler.sv
module byte_assembler
    import usb_rx_pkg::*;
(
    input  logic     tb_clk,
    input  logic     tb_n_rst,
    input  rx_bit_t  bit_out,
    output rx_byte_t byte_out
);

    logic [7:0] shift;
    logic [7:0] next_shift;
    logic [2:0] count;

    // LSB arrives first and ends up at bit 0
    assign next_shift = {bit_out.value, shift[7:1]};

    always_ff @(posedge tb_clk) begin
        if (bit_out.valid) begin
            shift <= next_shift;
        end
    end

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            count    <= '0;
            byte_out <= '0;
        end else begin
            byte_out <= '0;
            if (bit_out.valid) begin
                count <= count + 3'd1;
                if (count == 3'd7) begin
                    byte_out.valid <= 1'b1;
                    byte_out.data  <= next_shift;
                end
            end else if (bit_out.eop) begin
                // aligned when no partial byte is pending
                byte_out.eop     <= 1'b1;
                byte_out.aligned <= (count == 3'd0);
                count            <= '0;
            end
        end
    end

endmodule

// File: source/rx_controller.sv
module rx_controller
    import usb_rx_pkg::*;
#(
    parameter logic [6:0] dev_addr = 7'h70,
    parameter logic [3:0] dev_endp = 4'd4
) (
    input  logic       tb_clk,
    input  logic       tb_n_rst,
    input  rx_byte_t   byte_out,
    output logic       store,
    output logic [7:0] store_data,
    output rx_packet_t rx_packet,
    output logic       packet_done,
    output logic       r_error
);

    rx_state_t  state;
    rx_packet_t kind;
    logic [1:0] byte_cnt;
    logic       tok_match;
    logic [7:0] hold_old;
    logic [7:0] hold_new;
    logic       pid_ok;
    logic       addr_ok;
    logic       endp_ok;
    logic       shift_in;
    logic       done_ok;

    // ********************
    // byte checks
    // ********************

    assign pid_ok = (byte_out.data[3:0] == ~byte_out.data[7:4]);

    // first token byte sits in hold_new when the second arrives
    assign addr_ok = (hold_new[6:0] == dev_addr);
    assign endp_ok = ({byte_out.data[2:0], hold_new[7]} == dev_endp);

    // token and payload bytes move through the hold-back pair
    assign shift_in = byte_out.valid && (state == ST_TOKEN || state == ST_DATA);

    always_comb begin
        case (state)
            ST_TOKEN: done_ok = tok_match && (byte_cnt == 2'd2);
            ST_DATA:  done_ok = (byte_cnt == 2'd2);
            default:  done_ok = 1'b0;
        endcase
    end

    // ********************
    // hold-back pair
    // ********************

    // the sync byte also parks in hold_new for one cycle
    always_ff @(posedge tb_clk) begin
        if (shift_in || (byte_out.valid && state == ST_IDLE)) begin
            hold_old <= hold_new;
            hold_new <= byte_out.data;
        end
        if (shift_in) begin
            store_data <= hold_old;
        end
    end

    // ********************
    // packet FSM
    // ********************

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state       <= ST_IDLE;
            kind        <= PKT_NONE;
            byte_cnt    <= '0;
            tok_match   <= 1'b0;
            store       <= 1'b0;
            rx_packet   <= PKT_NONE;
            packet_done <= 1'b0;
            r_error     <= 1'b0;
        end else begin
            // oldest held byte leaves once two newer ones are behind it
            store <= shift_in && (state == ST_DATA) && (byte_cnt == 2'd2);
            if (shift_in && byte_cnt != 2'd2) begin
                byte_cnt <= byte_cnt + 2'd1;
            end
            if (shift_in && state == ST_TOKEN && byte_cnt == 2'd1) begin
                tok_match <= addr_ok && endp_ok;
            end

            case (state)
                ST_IDLE: begin
                    if (byte_out.valid || byte_out.eop) begin
                        rx_packet   <= PKT_NONE;
                        packet_done <= 1'b0;
                        // EOP before a whole sync byte
                        r_error     <= byte_out.eop;
                    end
                    if (byte_out.valid) begin
                        state <= ST_SYNC;
                    end
                end
                ST_SYNC: begin
                    if (hold_new == SYNC_BYTE) begin
                        state <= ST_PID;
                    end else begin
                        r_error <= 1'b1;
                        state   <= ST_WAIT_EOP;
                    end
                end
                ST_PID: begin
                    byte_cnt <= '0;
                    if (byte_out.eop) begin
                        r_error <= 1'b1;
                        state   <= ST_IDLE;
                    end else if (byte_out.valid && !pid_ok) begin
                        r_error <= 1'b1;
                        state   <= ST_WAIT_EOP;
                    end else if (byte_out.valid) begin
                        case (pid_t'(byte_out.data))
                            PID_IN: begin
                                kind  <= PKT_IN;
                                state <= ST_TOKEN;
                            end
                            PID_OUT: begin
                                kind  <= PKT_OUT;
                                state <= ST_TOKEN;
                            end
                            PID_DATA0, PID_DATA1: begin
                                kind  <= PKT_DATA;
                                state <= ST_DATA;
                            end
                            PID_ACK: begin
                                kind  <= PKT_ACK;
                                state <= ST_HANDSHAKE;
                            end
                            PID_NAK: begin
                                kind  <= PKT_NAK;
                                state <= ST_HANDSHAKE;
                            end
                            default: begin
                                kind  <= PKT_UNSUPPORTED;
                                state <= ST_HANDSHAKE;
                            end
                        endcase
                    end
                end
                ST_TOKEN, ST_DATA, ST_HANDSHAKE: begin
                    // trailing bytes are ignored and only the EOP reports status
                    if (byte_out.eop) begin
                        rx_packet   <= kind;
                        packet_done <= byte_out.aligned && done_ok;
                        r_error     <= !byte_out.aligned;
                        state       <= ST_IDLE;
                    end
                end
                ST_WAIT_EOP: begin
                    if (byte_out.eop) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/rx_fifo.sv
module rx_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic       tb_clk,
    input  logic       tb_n_rst,
    input  logic       store,
    input  logic [7:0] store_data,
    input  logic       r_enable,
    output logic [7:0] r_data,
    output logic       empty,
    output logic       full
);

    localparam int PTR_W = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int CNT_W = $clog2(fifo_depth + 1);

    logic [7:0]       mem [fifo_depth];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(fifo_depth - 1)) ? '0 : ptr + PTR_W'(1);
    endfunction

    // a byte that arrives while full is lost
    assign push = store && !full;
    assign pop  = r_enable && !empty;

    always_ff @(posedge tb_clk) begin
        if (push) begin
            mem[wr_ptr] <= store_data;
        end
    end

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    // first word falls through
    assign r_data = mem[rd_ptr];
    assign empty  = (count == '0);
    assign full   = (count == CNT_W'(fifo_depth));

endmodule

// File: source/usb_rx.sv
module usb_rx
    import usb_rx_pkg::*;
#(
    parameter int         clks_per_bit = 8,
    parameter logic [6:0] dev_addr     = 7'h70,
    parameter logic [3:0] dev_endp     = 4'd4,
    parameter int         fifo_depth   = 8
) (
    input  logic       tb_clk,
    input  logic       tb_n_rst,
    input  logic       d_plus,
    input  logic       d_minus,
    input  logic       r_enable,
    output rx_packet_t rx_packet,
    output logic       packet_done,
    output logic       r_error,
    output logic [7:0] r_data,
    output logic       empty,
    output logic       full
);

    line_state_t line;
    logic        sample;
    rx_bit_t     bit_out;
    rx_byte_t    byte_out;
    logic        store;
    logic [7:0]  store_data;

    // receive chain, one clock per stage
    line_sampler #(
        .clks_per_bit(clks_per_bit)
    ) u_line_sampler (
        .tb_clk  (tb_clk),
        .tb_n_rst(tb_n_rst),
        .d_plus  (d_plus),
        .d_minus (d_minus),
        .line    (line),
        .sample  (sample)
    );

    nrzi_decoder u_nrzi_decoder (
        .tb_clk  (tb_clk),
        .tb_n_rst(tb_n_rst),
        .line    (line),
        .sample  (sample),
        .bit_out (bit_out)
    );

    byte_assembler u_byte_assembler (
        .tb_clk  (tb_clk),
        .tb_n_rst(tb_n_rst),
        .bit_out (bit_out),
        .byte_out(byte_out)
    );

    rx_controller #(
        .dev_addr(dev_addr),
        .dev_endp(dev_endp)
    ) u_rx_controller (
        .tb_clk     (tb_clk),
        .tb_n_rst   (tb_n_rst),
        .byte_out   (byte_out),
        .store      (store),
        .store_data (store_data),
        .rx_packet  (rx_packet),
        .packet_done(packet_done),
        .r_error    (r_error)
    );

    rx_fifo #(
        .fifo_depth(fifo_depth)
    ) u_rx_fifo (
        .tb_clk    (tb_clk),
        .tb_n_rst  (tb_n_rst),
        .store     (store),
        .store_data(store_data),
        .r_enable  (r_enable),
        .r_data    (r_data),
        .empty     (empty),
        .full      (full)
    );

endmodule

// File: include/usb_bus_model.svh
`ifndef USB_BUS_MODEL_SVH
`define USB_BUS_MODEL_SVH

// bus model tasks, they drive d_plus and d_minus of the including module on tb_clk

localparam int BUS_CLKS_PER_BIT = 8;

// ones sent since the last zero
int bus_ones;

// one line level for a whole bit cell, set 2 ns after the edge
task automatic drive_level(input logic dp, input logic dm);
    @(posedge tb_clk);
    #2ns;
    d_plus  = dp;
    d_minus = dm;
    repeat (BUS_CLKS_PER_BIT - 1) @(posedge tb_clk);
endtask

// nrzi without stuffing, a zero toggles the line
task automatic send_raw_bit(input logic b);
    if (b) begin
        drive_level(d_plus, d_minus);
    end else begin
        drive_level(!d_plus, !d_minus);
    end
endtask

task automatic send_bit(input logic b);
    send_raw_bit(b);
    if (!b) begin
        bus_ones = 0;
    end else begin
        bus_ones++;
        if (bus_ones == usb_rx_pkg::STUFF_RUN) begin
            send_raw_bit(1'b0);
            bus_ones = 0;
        end
    end
endtask

// LSB first
task automatic send_byte(input logic [7:0] data);
    for (int i = 0; i < 8; i++) begin
        send_bit(data[i]);
    end
endtask

task automatic send_sync();
    bus_ones = 0;
    send_byte(usb_rx_pkg::SYNC_BYTE);
endtask

// two cells of SE0
task automatic send_eop();
    drive_level(1'b0, 1'b0);
    drive_level(1'b0, 1'b0);
    bus_ones = 0;
endtask

task automatic send_idle(input int cells);
    repeat (cells) drive_level(1'b1, 1'b0);
endtask

`endif

// File: tests/tb_usb_rx.sv
module tb_usb_rx
    import usb_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] dev_addr = 7'h70;
    localparam logic [3:0] dev_endp = 4'd4;

    logic        tb_clk;
    logic        tb_n_rst;
    logic        d_plus;
    logic        d_minus;
    logic        r_enable;
    rx_packet_t  rx_packet;
    logic        packet_done;
    logic        r_error;
    logic [7:0]  r_data;
    logic        empty;
    logic        full;

    logic [15:0] lfsr_state;
    // bytes after sync, and payload expected in the FIFO
    logic [7:0]  pkt_bytes[$];
    logic [7:0]  exp_fifo[$];

    `include "usb_bus_model.svh"

    usb_rx #(
        .clks_per_bit(8),
        .dev_addr    (dev_addr),
        .dev_endp    (dev_endp),
        .fifo_depth  (8)
    ) u_usb_rx (
        .tb_clk     (tb_clk),
        .tb_n_rst   (tb_n_rst),
        .d_plus     (d_plus),
        .d_minus    (d_minus),
        .r_enable   (r_enable),
        .rx_packet  (rx_packet),
        .packet_done(packet_done),
        .r_error    (r_error),
        .r_data     (r_data),
        .empty      (empty),
        .full       (full)
    );

    initial begin
        tb_clk = 1'b0;
        forever #10ns tb_clk = ~tb_clk;
    end

    // ********************
    // helpers
    // ********************

    // fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
        return b;
    endfunction

    // outputs are settled 2 ns after the edge
    task automatic next_cycle();
        @(posedge tb_clk);
        #2ns;
    endtask

    task automatic check_packet(input string name, input rx_packet_t got, input rx_packet_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // sync, pkt_bytes, optional stray bit, then EOP
    task automatic send_packet(input logic bad_sync, input logic extra_bit);
        send_idle(4);
        if (bad_sync) begin
            bus_ones = 0;
            send_byte(8'h82);
        end else begin
            send_sync();
        end
        for (int i = 0; i < pkt_bytes.size(); i++) begin
            send_byte(pkt_bytes[i]);
        end
        if (extra_bit) begin
            send_raw_bit(1'b0);
        end
        send_eop();
        send_idle(2);
    endtask

    task automatic wait_status();
        int n;
        n = 0;
        next_cycle();
        while (rx_packet == PKT_NONE && !r_error && n < 40) begin
            next_cycle();
            n++;
        end
        if (rx_packet == PKT_NONE && !r_error) begin
            $display("timeout: no packet status within 40 clocks after the packet");
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic expect_status(input rx_packet_t kind, input logic done, input logic err);
        wait_status();
        check_packet("rx_packet", rx_packet, kind);
        check_flag("packet_done", packet_done, done);
        check_flag("r_error", r_error, err);
    endtask

    task automatic pop_and_check(input logic [7:0] exp);
        check_flag("empty", empty, 1'b0);
        check_byte("r_data", r_data, exp);
        r_enable = 1'b1;
        next_cycle();
        r_enable = 1'b0;
    endtask

    task automatic drain_and_check();
        while (exp_fifo.size() > 0) begin
            pop_and_check(exp_fifo.pop_front());
        end
        check_flag("empty", empty, 1'b1);
    endtask

    // token field is addr, endp, crc5, LSB first
    task automatic send_token(input logic [7:0] pid, input logic [6:0] addr,
                              input logic [3:0] endp);
        logic [7:0]  crc;
        logic [15:0] field;
        crc = random_byte();
        field = {crc[4:0], endp, addr};
        pkt_bytes.delete();
        pkt_bytes.push_back(pid);
        pkt_bytes.push_back(field[7:0]);
        pkt_bytes.push_back(field[15:8]);
        send_packet(1'b0, 1'b0);
    endtask

    // ********************
    // directed tests
    // ********************

    task automatic test_reset();
        check_packet("rx_packet", rx_packet, PKT_NONE);
        check_flag("packet_done", packet_done, 1'b0);
        check_flag("r_error", r_error, 1'b0);
        check_flag("empty", empty, 1'b1);
        check_flag("full", full, 1'b0);
    endtask

    task automatic test_data0();
        logic [7:0] b;
        pkt_bytes.delete();
        exp_fifo.delete();
        pkt_bytes.push_back(PID_DATA0);
        for (int i = 0; i < 4; i++) begin
            b = random_byte();
            pkt_bytes.push_back(b);
            exp_fifo.push_back(b);
        end
        // crc bytes, never stored
        pkt_bytes.push_back(random_byte());
        pkt_bytes.push_back(random_byte());
        send_packet(1'b0, 1'b0);
        expect_status(PKT_DATA, 1'b1, 1'b0);
        drain_and_check();
    endtask

    // runs of ones force stuffed zeros on the line
    task automatic test_data1_stuffing();
        pkt_bytes.delete();
        exp_fifo.delete();
        exp_fifo.push_back(8'hFF);
        exp_fifo.push_back(8'hFF);
        exp_fifo.push_back(random_byte());
        exp_fifo.push_back(8'hFF);
        pkt_bytes.push_back(PID_DATA1);
        for (int i = 0; i < exp_fifo.size(); i++) begin
            pkt_bytes.push_back(exp_fifo[i]);
        end
        pkt_bytes.push_back(8'hFF);
        pkt_bytes.push_back(random_byte());
        send_packet(1'b0, 1'b0);
        expect_status(PKT_DATA, 1'b1, 1'b0);
        drain_and_check();
    endtask

    task automatic test_tokens();
        send_token(PID_IN, dev_addr, dev_endp);
        expect_status(PKT_IN, 1'b1, 1'b0);
        send_token(PID_OUT, dev_addr, dev_endp);
        expect_status(PKT_OUT, 1'b1, 1'b0);
        send_token(PID_IN, 7'h15, dev_endp);
        expect_status(PKT_IN, 1'b0, 1'b0);
        send_token(PID_IN, dev_addr, 4'd5);
        expect_status(PKT_IN, 1'b0, 1'b0);
    endtask

    task automatic test_handshakes();
        pkt_bytes.delete();
        pkt_bytes.push_back(PID_ACK);
        pkt_bytes.push_back(random_byte());
        send_packet(1'b0, 1'b0);
        expect_status(PKT_ACK, 1'b0, 1'b0);
        pkt_bytes.delete();
        pkt_bytes.push_back(PID_NAK);
        pkt_bytes.push_back(random_byte());
        send_packet(1'b0, 1'b0);
        expect_status(PKT_NAK, 1'b0, 1'b0);
        // valid nibbles but no such pid
        pkt_bytes.delete();
        pkt_bytes.push_back(8'hF0);
        send_packet(1'b0, 1'b0);
        expect_status(PKT_UNSUPPORTED, 1'b0, 1'b0);
        check_flag("empty", empty, 1'b1);
    endtask

    task automatic test_errors();
        logic [7:0] b;
        pkt_bytes.delete();
        pkt_bytes.push_back(PID_DATA0);
        pkt_bytes.push_back(random_byte());
        send_packet(1'b1, 1'b0);
        expect_status(PKT_NONE, 1'b0, 1'b1);
        check_flag("empty", empty, 1'b1);

        // nibbles not complementary
        pkt_bytes.delete();
        pkt_bytes.push_back(8'hC4);
        pkt_bytes.push_back(random_byte());
        send_packet(1'b0, 1'b0);
        expect_status(PKT_NONE, 1'b0, 1'b1);

        // EOP mid byte, only the first payload byte got past the hold-back
        pkt_bytes.delete();
        exp_fifo.delete();
        pkt_bytes.push_back(PID_DATA0);
        for (int i = 0; i < 3; i++) begin
            b = random_byte();
            pkt_bytes.push_back(b);
            if (i == 0) begin
                exp_fifo.push_back(b);
            end
        end
        send_packet(1'b0, 1'b1);
        expect_status(PKT_DATA, 1'b0, 1'b1);
        drain_and_check();
    endtask

    initial begin
        tb_n_rst   = 1'b0;
        d_plus     = 1'b1;
        d_minus    = 1'b0;
        r_enable   = 1'b0;
        bus_ones   = 0;
        lfsr_state = 16'd22894;
        repeat (3) @(posedge tb_clk);
        #2ns;
        tb_n_rst = 1'b1;
        next_cycle();

        test_reset();
        test_data0();
        test_data1_stuffing();
        test_tokens();
        test_handshakes();
        test_errors();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
source/usb_rx_pkg.sv
source/line_sampler.sv
source/nrzi_decoder.sv
source/byte_assembler.sv
source/rx_controller.sv
source/rx_fifo.sv
source/usb_rx.sv
tests/tb_usb_rx.sv
